/* verilog/axiLite_consts.svh */
`ifndef AXILITE_CONSTS_SVH
`define AXILITE_CONSTS_SVH

// bus widths.
`define AXIL_ADDR_W 32
`define AXIL_DATA_W 32

// register map size with the ID word last.
`define AXIL_REG_COUNT 8

`define AXIL_RESP_OKAY   2'b00
`define AXIL_RESP_SLVERR 2'b10

// value returned by register 7.
`define AXIL_ID_VALUE 32'hA11E_0107

`define AXIL_PROT_REG 6

`endif

/* verilog/axiLitePkg.sv */
`default_nettype none

`include "axiLite_consts.svh"

package axiLitePkg;

  // stored word seen whole or as byte lanes for strobe merging.
  typedef union packed {
    logic [`AXIL_DATA_W-1:0] raw;
    logic [`AXIL_DATA_W/8-1:0][7:0] bytes;
  } regWord_u;

  typedef struct packed {
    logic [`AXIL_ADDR_W-1:0] addr;
    logic [`AXIL_DATA_W-1:0] data;
    logic [`AXIL_DATA_W/8-1:0] strb;
    logic [2:0] prot;
  } wrReq_t;

  typedef struct packed {
    logic [`AXIL_ADDR_W-1:0] addr;
    logic [2:0] prot;
  } rdReq_t;

  typedef struct packed {
    logic [1:0] resp;
  } wrRsp_t;

  typedef struct packed {
    logic [`AXIL_DATA_W-1:0] data;
    logic [1:0] resp;
  } rdRsp_t;

endpackage : axiLitePkg

`default_nettype wire

/* verilog/axiLiteWriteChannel.sv */
`timescale 1ns/1ps
`default_nettype none

`include "axiLite_consts.svh"

module axiLiteWriteChannel (
  input  logic aclk,
  input  logic arstN,
  input  logic awvalid,
  output logic awready,
  input  logic [`AXIL_ADDR_W-1:0] awaddr,
  input  logic [2:0] awprot,
  input  logic wvalid,
  output logic wready,
  input  logic [`AXIL_DATA_W-1:0] wdata,
  input  logic [`AXIL_DATA_W/8-1:0] wstrb,
  output logic bvalid,
  input  logic bready,
  output logic [1:0] bresp,
  output logic wrValid,
  output axiLitePkg::wrReq_t wrReq,
  input  axiLitePkg::wrRsp_t wrRsp
);

  logic readyEn;
  logic awFull;
  logic wFull;
  logic [`AXIL_ADDR_W-1:0] awAddrQ;
  logic [2:0] awProtQ;
  logic [`AXIL_DATA_W-1:0] wDataQ;
  logic [`AXIL_DATA_W/8-1:0] wStrbQ;
  logic awFire;
  logic wFire;

  // no new address or data while a response waits.
  assign awready = readyEn & ~awFull & ~bvalid;
  assign wready  = readyEn & ~wFull & ~bvalid;
  assign awFire  = awvalid & awready;
  assign wFire   = wvalid & wready;

  assign wrValid = awFull & wFull; // slots clear on issue so this lasts one cycle.

  always_comb begin
    wrReq.addr = awAddrQ;
    wrReq.prot = awProtQ;
    wrReq.data = wDataQ;
    wrReq.strb = wStrbQ;
  end

  always_ff @(posedge aclk or negedge arstN) begin
    if (!arstN) begin
      readyEn <= 1'b0;
      awFull  <= 1'b0;
      wFull   <= 1'b0;
      bvalid  <= 1'b0;
    end else begin
      readyEn <= 1'b1;
      if (awFire) awFull <= 1'b1;
      if (wFire) wFull <= 1'b1;
      if (wrValid) begin
        awFull <= 1'b0;
        wFull  <= 1'b0;
        bvalid <= 1'b1;
      end else if (bvalid && bready) begin
        bvalid <= 1'b0;
      end
    end
  end

  // address and data slots.
  always_ff @(posedge aclk) begin
    if (awFire) begin
      awAddrQ <= awaddr;
      awProtQ <= awprot;
    end
    if (wFire) begin
      wDataQ <= wdata;
      wStrbQ <= wstrb;
    end
    if (wrValid) bresp <= wrRsp.resp; // held until bready.
  end

endmodule : axiLiteWriteChannel

`default_nettype wire

/* verilog/axiLiteReadChannel.sv */
`timescale 1ns/1ps
`default_nettype none

`include "axiLite_consts.svh"

module axiLiteReadChannel (
  input  logic aclk,
  input  logic arstN,
  input  logic arvalid,
  output logic arready,
  input  logic [`AXIL_ADDR_W-1:0] araddr,
  input  logic [2:0] arprot,
  output logic rvalid,
  input  logic rready,
  output logic [`AXIL_DATA_W-1:0] rdata,
  output logic [1:0] rresp,
  output logic rdValid,
  output axiLitePkg::rdReq_t rdReq,
  input  axiLitePkg::rdRsp_t rdRsp
);

  logic readyEn;

  assign arready = readyEn & ~rvalid;

  // request goes to the bank in the handshake cycle.
  assign rdValid = arvalid & arready;

  always_comb begin
    rdReq.addr = araddr;
    rdReq.prot = arprot;
  end

  always_ff @(posedge aclk or negedge arstN) begin
    if (!arstN) begin
      readyEn <= 1'b0;
      rvalid  <= 1'b0;
    end else begin
      readyEn <= 1'b1;
      if (rdValid) begin
        rvalid <= 1'b1;
      end else if (rready) begin
        rvalid <= 1'b0;
      end
    end
  end

  // response stays put under back-pressure.
  always_ff @(posedge aclk) begin
    if (rdValid) begin
      rdata <= rdRsp.data;
      rresp <= rdRsp.resp;
    end
  end

endmodule : axiLiteReadChannel

`default_nettype wire

/* verilog/axiLiteRegBank.sv */
`timescale 1ns/1ps
`default_nettype none

`include "axiLite_consts.svh"

module axiLiteRegBank (
  input  logic aclk,
  input  logic arstN,
  input  logic wrValid,
  input  axiLitePkg::wrReq_t wrReq,
  output axiLitePkg::wrRsp_t wrRsp,
  input  logic rdValid,
  input  axiLitePkg::rdReq_t rdReq,
  output axiLitePkg::rdRsp_t rdRsp
);

  localparam int IdxW = $clog2(`AXIL_REG_COUNT);
  localparam int IdReg = `AXIL_REG_COUNT - 1;
  localparam int Lanes = `AXIL_DATA_W / 8;

  // storage for every register but the ID word.
  axiLitePkg::regWord_u regs [IdReg];

  logic [IdxW-1:0] wrIdx;
  logic [IdxW-1:0] rdIdx;
  logic wrInRange;
  logic rdInRange;
  logic wrErr;

  assign wrIdx = wrReq.addr[IdxW+1:2];
  assign rdIdx = rdReq.addr[IdxW+1:2];
  assign wrInRange = ~|wrReq.addr[`AXIL_ADDR_W-1:IdxW+2];
  assign rdInRange = ~|rdReq.addr[`AXIL_ADDR_W-1:IdxW+2];

  // ID is read-only and register 6 needs a privileged write.
  assign wrErr = !wrInRange || (wrIdx == IdxW'(IdReg)) ||
                 ((wrIdx == IdxW'(`AXIL_PROT_REG)) && !wrReq.prot[0]);

  assign wrRsp.resp = wrErr ? `AXIL_RESP_SLVERR : `AXIL_RESP_OKAY;

  always_comb begin
    rdRsp.data = '0;
    rdRsp.resp = `AXIL_RESP_OKAY;
    if (rdValid) begin
      if (!rdInRange) begin
        rdRsp.resp = `AXIL_RESP_SLVERR; // data stays zero.
      end else if (rdIdx == IdxW'(IdReg)) begin
        rdRsp.data = `AXIL_ID_VALUE;
      end else begin
        for (int i = 0; i < IdReg; i++) begin
          if (rdIdx == IdxW'(i)) rdRsp.data = regs[i].raw;
        end
      end
    end
  end

  // byte merge per strobe lane.
  always_ff @(posedge aclk or negedge arstN) begin
    if (!arstN) begin
      for (int i = 0; i < IdReg; i++) begin
        regs[i].raw <= '0;
      end
    end else if (wrValid && !wrErr) begin
      for (int i = 0; i < IdReg; i++) begin
        if (wrIdx == IdxW'(i)) begin
          for (int b = 0; b < Lanes; b++) begin
            if (wrReq.strb[b]) regs[i].bytes[b] <= wrReq.data[8*b +: 8];
          end
        end
      end
    end
  end

endmodule : axiLiteRegBank

`default_nettype wire

/* verilog/axiLiteSlaveTop.sv */
`timescale 1ns/1ps
`default_nettype none

`include "axiLite_consts.svh"

module axiLiteSlaveTop (
  input  logic aclk,
  input  logic arstN,
  input  logic awvalid,
  output logic awready,
  input  logic [`AXIL_ADDR_W-1:0] awaddr,
  input  logic [2:0] awprot,
  input  logic wvalid,
  output logic wready,
  input  logic [`AXIL_DATA_W-1:0] wdata,
  input  logic [`AXIL_DATA_W/8-1:0] wstrb,
  output logic bvalid,
  input  logic bready,
  output logic [1:0] bresp,
  input  logic arvalid,
  output logic arready,
  input  logic [`AXIL_ADDR_W-1:0] araddr,
  input  logic [2:0] arprot,
  output logic rvalid,
  input  logic rready,
  output logic [`AXIL_DATA_W-1:0] rdata,
  output logic [1:0] rresp
);

  logic wrValid;
  logic rdValid;
  axiLitePkg::wrReq_t wrReq;
  axiLitePkg::wrRsp_t wrRsp;
  axiLitePkg::rdReq_t rdReq;
  axiLitePkg::rdRsp_t rdRsp;

  axiLiteWriteChannel uWriteChannel (
    .aclk    (aclk),
    .arstN   (arstN),
    .awvalid (awvalid),
    .awready (awready),
    .awaddr  (awaddr),
    .awprot  (awprot),
    .wvalid  (wvalid),
    .wready  (wready),
    .wdata   (wdata),
    .wstrb   (wstrb),
    .bvalid  (bvalid),
    .bready  (bready),
    .bresp   (bresp),
    .wrValid (wrValid),
    .wrReq   (wrReq),
    .wrRsp   (wrRsp)
  );

  axiLiteReadChannel uReadChannel (
    .aclk    (aclk),
    .arstN   (arstN),
    .arvalid (arvalid),
    .arready (arready),
    .araddr  (araddr),
    .arprot  (arprot),
    .rvalid  (rvalid),
    .rready  (rready),
    .rdata   (rdata),
    .rresp   (rresp),
    .rdValid (rdValid),
    .rdReq   (rdReq),
    .rdRsp   (rdRsp)
  );

  // one decode point for both directions.
  axiLiteRegBank uRegBank (
    .aclk    (aclk),
    .arstN   (arstN),
    .wrValid (wrValid),
    .wrReq   (wrReq),
    .wrRsp   (wrRsp),
    .rdValid (rdValid),
    .rdReq   (rdReq),
    .rdRsp   (rdRsp)
  );

endmodule : axiLiteSlaveTop

`default_nettype wire

/* sim/axiLiteSlave_chk.sv */
`timescale 1ns/1ps
`default_nettype none

`include "axiLite_consts.svh"

module axiLiteSlave_chk (
  input logic aclk, arstN,
  input logic awvalid, awready, wvalid, wready, bvalid, bready,
  input logic arvalid, arready, rvalid, rready,
  input logic [`AXIL_ADDR_W-1:0] awaddr, araddr,
  input logic [`AXIL_DATA_W-1:0] wdata, rdata,
  input logic [`AXIL_DATA_W/8-1:0] wstrb,
  input logic [2:0] awprot, arprot,
  input logic [1:0] bresp, rresp
);

  int failCount = 0;

  // a waiting valid keeps its payload.
  assert property (@(posedge aclk) disable iff (!arstN)
    awvalid && !awready |=> awvalid && $stable({awaddr, awprot}))
    else begin
      failCount++;
      $error("AW dropped or changed before handshake");
    end
  assert property (@(posedge aclk) disable iff (!arstN)
    wvalid && !wready |=> wvalid && $stable({wdata, wstrb}))
    else begin
      failCount++;
      $error("W dropped or changed before handshake");
    end
  assert property (@(posedge aclk) disable iff (!arstN)
    bvalid && !bready |=> bvalid && $stable(bresp))
    else begin
      failCount++;
      $error("B dropped or changed before handshake");
    end
  assert property (@(posedge aclk) disable iff (!arstN)
    arvalid && !arready |=> arvalid && $stable({araddr, arprot}))
    else begin
      failCount++;
      $error("AR dropped or changed before handshake");
    end
  assert property (@(posedge aclk) disable iff (!arstN)
    rvalid && !rready |=> rvalid && $stable({rdata, rresp}))
    else begin
      failCount++;
      $error("R dropped or changed before handshake");
    end

  assert property (@(posedge aclk) !arstN |-> !bvalid && !rvalid)
    else begin
      failCount++;
      $error("response valid high during reset");
    end

endmodule : axiLiteSlave_chk

`default_nettype wire

/* sim/axiLiteSlaveTb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "axiLite_consts.svh"

module axiLiteSlaveTb;

  localparam int TimeoutCycles = 64;
  localparam int ChAw = 0, ChW = 1, ChAr = 2, ChB = 3, ChR = 4;

  logic aclk, arstN;
  logic awvalid, wvalid, bready, arvalid, rready;
  logic awready, wready, bvalid, arready, rvalid;
  logic [`AXIL_ADDR_W-1:0] awaddr, araddr;
  logic [`AXIL_DATA_W-1:0] wdata, rdata;
  logic [`AXIL_DATA_W/8-1:0] wstrb;
  logic [2:0] awprot, arprot;
  logic [1:0] bresp, rresp;

  logic [31:0] gotData, gotResp;
  int errorCount = 0;
  int testCount = 0;
  int failedTests = 0;
  bit timedOut = 1'b0;

  axiLiteSlaveTop u_dut (.*);

  bind axiLiteSlaveTop axiLiteSlave_chk uChk (.*);

  initial begin
    aclk = 1'b0;
    forever #20 aclk = ~aclk;
  end

  task automatic compare(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
    if (expected !== actual) begin
      $display("[ERROR] %s expected 0x%08h got 0x%08h", name, expected, actual);
      errorCount++;
    end
  endtask

  function automatic logic fires(input int ch);
    case (ch)
      ChAw: return awready;
      ChW: return wready;
      ChAr: return arready;
      ChB: return bvalid && bready;
      default: return rvalid && rready;
    endcase
  endfunction

  // random back-pressure on B and R only.
  task automatic randomizeReady(input int ch);
    if (ch == ChB) bready = (($urandom % 3) != 0);
    if (ch == ChR) rready = (($urandom % 3) != 0);
  endtask

  // checked at a falling edge so the handshake lands on the next rising edge.
  task automatic waitFor(input int ch, input string what);
    int cycles;
    if (timedOut) return;
    cycles = 0;
    randomizeReady(ch);
    while (!fires(ch) && cycles < TimeoutCycles) begin
      @(negedge aclk);
      cycles++;
      randomizeReady(ch);
    end
    if (fires(ch)) begin
      gotData = rdata;
      gotResp = (ch == ChB) ? 32'(bresp) : 32'(rresp);
      @(negedge aclk);
      bready = 1'b0;
      rready = 1'b0;
    end else begin
      $display("timeout: no %s handshake within %0d cycles", what, TimeoutCycles);
      timedOut = 1'b1;
      errorCount++;
    end
  endtask

  task automatic sendAw();
    awvalid = 1'b1;
    waitFor(ChAw, "AW");
    if (!timedOut) awvalid = 1'b0;
  endtask

  task automatic sendW();
    wvalid = 1'b1;
    waitFor(ChW, "W");
    if (!timedOut) wvalid = 1'b0;
  endtask

  task automatic doWrite(input logic [31:0] addr, input logic [31:0] data,
                         input logic [3:0] strb, input logic [2:0] prot,
                         input logic [31:0] order);
    awaddr = addr;
    awprot = prot;
    wdata = data;
    wstrb = strb;
    case (order)
      0: begin // AW first.
        sendAw();
        sendW();
      end
      1: begin
        sendW();
        sendAw();
      end
      default: fork
        sendAw();
        sendW();
      join
    endcase
    waitFor(ChB, "B");
  endtask

  task automatic doRead(input logic [31:0] addr, input logic [2:0] prot);
    araddr = addr;
    arprot = prot;
    arvalid = 1'b1;
    waitFor(ChAr, "AR");
    if (!timedOut) arvalid = 1'b0;
    waitFor(ChR, "R");
  endtask

  initial begin
    int fd, n, errsBefore;
    string line;
    logic [31:0] op, addr, data, strb, prot, order, expData, expResp;
    void'($urandom(79));
    arstN = 1'b0;
    {awvalid, wvalid, bready, arvalid, rready} = '0;
    {awaddr, araddr, wdata, wstrb, awprot, arprot} = '0;
    repeat (4) @(posedge aclk);
    @(negedge aclk);
    arstN = 1'b1;
    fd = $fopen("sim/axiLiteStimulus.txt", "r");
    if (fd == 0) begin
      $display("could not open sim/axiLiteStimulus.txt");
      errorCount++;
    end else begin
      while (!$feof(fd) && !timedOut) begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() == 0 || line[0] == "#") continue;
        n = $sscanf(line, "%h %h %h %h %h %h %h %h",
                    op, addr, data, strb, prot, order, expData, expResp);
        if (n <= 0) continue; // blank line.
        if (n != 8) begin
          $display("stimulus line has %0d fields instead of 8: %s", n, line);
          errorCount++;
          continue;
        end
        errsBefore = errorCount;
        if (op == 0) begin
          doWrite(addr, data, strb[3:0], prot[2:0], order);
          compare("bresp", expResp, gotResp);
        end else begin
          doRead(addr, prot[2:0]);
          compare("rdata", expData, gotData);
          compare("rresp", expResp, gotResp);
        end
        testCount++;
        if (errorCount != errsBefore) failedTests++;
        $display("test %0d %s addr 0x%08h %s", testCount, (op == 0) ? "write" : "read ",
                 addr, (errorCount == errsBefore) ? "match   " : "mismatch");
      end
      $fclose(fd);
    end
    if (testCount == 0) begin
      $display("no transactions were run from the stimulus file");
      errorCount++;
    end
    $display("tests %0d, failed %0d, errors %0d, assertion failures %0d",
             testCount, failedTests, errorCount, u_dut.uChk.failCount);
    if (errorCount == 0 && u_dut.uChk.failCount == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule : axiLiteSlaveTb

`default_nettype wire

/* sim/axiLiteStimulus.txt */
# op addr data strb prot order expdata expresp, all hex
# op 0 write 1 read; order 0 AW first, 1 W first, 2 together
0 00000000 12345678 f 0 2 00000000 0
1 00000000 00000000 0 0 0 12345678 0
0 00000004 aabbccdd f 0 0 00000000 0
0 00000004 11223344 5 0 1 00000000 0
1 00000004 00000000 0 0 0 aa22cc44 0
0 00000020 deadbeef f 0 0 00000000 2
1 00000020 00000000 0 0 0 00000000 2
1 00000000 00000000 0 0 0 12345678 0
1 0000001c 00000000 0 0 0 a11e0107 0
0 0000001c 55555555 f 1 2 00000000 2
1 0000001c 00000000 0 0 0 a11e0107 0
0 00000018 cafef00d f 0 0 00000000 2
1 00000018 00000000 0 0 0 00000000 0
0 00000018 cafef00d f 1 1 00000000 0
1 00000018 00000000 0 0 0 cafef00d 0
0 00000008 01020304 f 0 0 00000000 0
0 0000000c 05060708 f 0 1 00000000 0
0 00000010 090a0b0c f 0 2 00000000 0
1 00000008 00000000 0 0 0 01020304 0
1 0000000c 00000000 0 0 0 05060708 0
1 00000010 00000000 0 0 0 090a0b0c 0
0 00000014 ffffffff 8 0 2 00000000 0
1 00000014 00000000 0 0 0 ff000000 0

/* all.f */
+incdir+verilog
verilog/axiLitePkg.sv
verilog/axiLiteWriteChannel.sv
verilog/axiLiteReadChannel.sv
verilog/axiLiteRegBank.sv
verilog/axiLiteSlaveTop.sv
sim/axiLiteSlave_chk.sv
sim/axiLiteSlaveTb.sv

/* Makefile */
TOOL     := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := axiLiteSlaveTb
FILELIST := all.f
OBJDIR   := obj_dir
BIN      := $(OBJDIR)/V$(TOP)
LOG      := sim.log
PASS     := Simulation finished: PASS
SOURCES  := $(shell grep -v '^+' $(FILELIST)) $(wildcard verilog/*.svh)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	@grep -qF "$(PASS)" $(LOG) || (echo "run failed, see $(LOG)" && exit 1)

clean:
	rm -rf $(OBJDIR) $(LOG)
